//--- Makefile
VERILATOR ?= verilator
TOP       ?= cp15Tb
DUT_TOP   ?= cp15Top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= ** PASS **

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF -- '$(PASS_TEXT)' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hw/cp15PipeReg.sv
`timescale 1ns/1ps

module cp15PipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    reset,
  input  payloadT inData,
  input  logic    inValid,
  output logic    inReady,
  output payloadT outData,
  output logic    outValid,
  input  logic    outReady
);

  logic    full;
  payloadT data;

  // Accept when empty or when the held item drains this cycle
  assign inReady = !full || outReady;

  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (inValid && inReady) begin
      full <= 1'b1;
    end else if (outReady) begin
      full <= 1'b0;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      data <= inData;
    end
  end

  assign outData = data;
  assign outValid = full;

endmodule

//--- hw/cp15Pkg.sv
package cp15Pkg;

  // Requester identity carried with every request and its response
  typedef enum logic {
    CP15_SRC_CPU = 1'b0,
    CP15_SRC_MMU = 1'b1
  } cp15SrcE;

  // Port request with write high for MCR and low for MRC
  typedef struct packed {
    logic        write;
    logic [3:0]  addr;
    logic [2:0]  opcode2;
    logic [3:0]  crm;
    logic [31:0] wdata;
  } cp15PortReqT;

  // Arbitrated request tagged with its source
  typedef struct packed {
    cp15PortReqT port;
    cp15SrcE     src;
  } cp15ReqT;

  // Cache and TLB maintenance strobes
  typedef struct packed {
    logic invI;
    logic invD;
    logic cleanI;
    logic cleanD;
    logic tlbFlushI;
    logic tlbFlushD;
  } cp15MaintT;

  typedef struct packed {
    cp15SrcE     src;
    logic [31:0] rdata;
    cp15MaintT   maint;
  } cp15RspT;

  // Maintenance register numbers
  localparam logic [3:0] CP15_REG_CACHE = 4'd7;
  localparam logic [3:0] CP15_REG_TLB   = 4'd8;

  // Writable bits per register with reg 15 first
  localparam logic [15:0][31:0] CP15_WRITE_MASK = {
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
    32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
    32'h0000_0000, 32'hFFFF_FFFF, 32'h0000_01FF, 32'h0000_0000,
    32'hFFFF_FFFF, 32'hFFFF_C000, 32'h0000_FFFF, 32'h0000_0000
  };

endpackage

//--- hw/cp15PortArbiter.sv
`timescale 1ns/1ps

module cp15PortArbiter (
  input  logic                 clk,
  input  logic                 reset,
  input  cp15Pkg::cp15PortReqT cpuReq,
  input  logic                 cpuValid,
  output logic                 cpuReady,
  input  cp15Pkg::cp15PortReqT mmuReq,
  input  logic                 mmuValid,
  output logic                 mmuReady,
  output cp15Pkg::cp15ReqT     outReq,
  output logic                 outValid,
  input  logic                 outReady
);

  import cp15Pkg::*;

  cp15SrcE lastGrant;
  logic    grantMmu;
  logic    transfer;

  // ********************
  // Grant selection
  // ********************

  // MMU wins when alone, or on a tie when the CPU went last
  assign grantMmu = mmuValid && (!cpuValid || lastGrant == CP15_SRC_CPU);

  assign outValid = cpuValid || mmuValid;
  assign outReq.port = grantMmu ? mmuReq : cpuReq;
  assign outReq.src = grantMmu ? CP15_SRC_MMU : CP15_SRC_CPU;

  // Only the granted side sees ready
  assign cpuReady = outReady && !grantMmu;
  assign mmuReady = outReady && grantMmu;

  assign transfer = outValid && outReady;

  // ********************
  // Fairness state
  // ********************

  // Reset to MMU so the CPU takes the first tie
  always_ff @(posedge clk) begin
    if (reset) begin
      lastGrant <= CP15_SRC_MMU;
    end else if (transfer) begin
      lastGrant <= outReq.src;
    end
  end

endmodule

//--- hw/cp15RegisterFile.sv
`timescale 1ns/1ps

module cp15RegisterFile #(
  parameter logic [31:0] idValue      = 32'h4106_9265,
  parameter logic [31:0] controlReset = 32'h0009_0078
) (
  input  logic             clk,
  input  logic             reset,
  input  cp15Pkg::cp15ReqT req,
  input  logic             reqValid,
  output logic             reqReady,
  output cp15Pkg::cp15RspT rsp,
  output logic             rspValid,
  input  logic             rspReady,
  output logic [31:0]      control,
  output logic [31:0]      tbase
);

  import cp15Pkg::*;

  logic [15:0][31:0] regs;
  logic [31:0]       mask;
  logic              commit;
  logic              maintOp;
  // invI, invD, cleanI, cleanD
  logic [3:0]        cacheOps;
  // tlbFlushI, tlbFlushD
  logic [1:0]        tlbOps;

  // Stage boundary is a straight pass of the handshake
  assign reqReady = rspReady;
  assign rspValid = reqValid;
  assign commit = reqValid && rspReady;

  assign mask = CP15_WRITE_MASK[req.port.addr];

  // ********************
  // Register storage
  // ********************

  // Reg 0 has an all-zero mask and keeps the ID forever
  always_ff @(posedge clk) begin
    if (reset) begin
      regs    <= '0;
      regs[0] <= idValue;
      regs[1] <= controlReset;
    end else if (commit && req.port.write) begin
      regs[req.port.addr] <= (regs[req.port.addr] & ~mask) | (req.port.wdata & mask);
    end
  end

  assign control = regs[1];
  assign tbase = regs[2];

  // ********************
  // Maintenance decode
  // ********************

  assign maintOp = req.port.write && (req.port.opcode2 inside {3'd0, 3'd1});

  always_comb begin
    cacheOps = 4'b0000;
    if (maintOp && req.port.addr == CP15_REG_CACHE) begin
      case (req.port.crm)
        4'd5:    cacheOps = 4'b1000;
        4'd6:    cacheOps = 4'b0100;
        4'd7:    cacheOps = 4'b1100;
        4'd10:   cacheOps = 4'b0001;
        4'd11:   cacheOps = 4'b0011;
        4'd14:   cacheOps = 4'b0101;
        4'd15:   cacheOps = 4'b1111;
        default: cacheOps = 4'b0000;
      endcase
    end
  end

  always_comb begin
    tlbOps = 2'b00;
    if (maintOp && req.port.addr == CP15_REG_TLB) begin
      case (req.port.crm)
        4'd5:    tlbOps = 2'b10;
        4'd6:    tlbOps = 2'b01;
        4'd7:    tlbOps = 2'b11;
        default: tlbOps = 2'b00;
      endcase
    end
  end

  // Writes return zero and unimplemented or maintenance regs hold zero
  assign rsp.src = req.src;
  assign rsp.rdata = req.port.write ? 32'h0 : regs[req.port.addr];
  assign rsp.maint = cp15MaintT'({cacheOps, tlbOps});

endmodule

//--- hw/cp15ResponseRouter.sv
`timescale 1ns/1ps

module cp15ResponseRouter (
  input  cp15Pkg::cp15RspT   rsp,
  input  logic               rspValid,
  output logic               rspReady,
  output logic [31:0]        cpuRspData,
  output logic               cpuRspValid,
  input  logic               cpuRspReady,
  output logic [31:0]        mmuRspData,
  output logic               mmuRspValid,
  input  logic               mmuRspReady,
  output cp15Pkg::cp15MaintT maint
);

  import cp15Pkg::*;

  logic toMmu;
  logic transfer;

  assign toMmu = rsp.src == CP15_SRC_MMU;

  // ********************
  // Port steering
  // ********************

  // Data goes to both ports and valid only to the issuer
  assign cpuRspData = rsp.rdata;
  assign mmuRspData = rsp.rdata;
  assign cpuRspValid = rspValid && !toMmu;
  assign mmuRspValid = rspValid && toMmu;

  // The other port's ready must not drain this response
  assign rspReady = toMmu ? mmuRspReady : cpuRspReady;

  assign transfer = rspValid && rspReady;

  // ********************
  // Maintenance strobes
  // ********************

  // One pulse per operation, in the cycle its response leaves
  assign maint = transfer ? rsp.maint : '0;

endmodule

//--- hw/cp15Top.sv
`timescale 1ns/1ps

module cp15Top #(
  parameter logic [31:0] idValue      = 32'h4106_9265,
  parameter logic [31:0] controlReset = 32'h0009_0078
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cp15Pkg::cp15PortReqT cpuReq,
  input  logic                 cpuValid,
  output logic                 cpuReady,
  input  cp15Pkg::cp15PortReqT mmuReq,
  input  logic                 mmuValid,
  output logic                 mmuReady,
  output logic [31:0]          cpuRspData,
  output logic                 cpuRspValid,
  input  logic                 cpuRspReady,
  output logic [31:0]          mmuRspData,
  output logic                 mmuRspValid,
  input  logic                 mmuRspReady,
  output cp15Pkg::cp15MaintT   maint,
  output logic [31:0]          control,
  output logic [31:0]          tbase
);

  import cp15Pkg::*;

  // Arbiter to pipe A
  cp15ReqT arbReq;
  logic    arbValid;
  logic    arbReady;
  // Pipe A to register file
  cp15ReqT pipeAReq;
  logic    pipeAValid;
  logic    pipeAReady;
  // Register file to pipe B
  cp15RspT rfRsp;
  logic    rfValid;
  logic    rfReady;
  // Pipe B to router
  cp15RspT pipeBRsp;
  logic    pipeBValid;
  logic    pipeBReady;

  cp15PortArbiter u_arbiter (
    .clk      (clk),
    .reset    (reset),
    .cpuReq   (cpuReq),
    .cpuValid (cpuValid),
    .cpuReady (cpuReady),
    .mmuReq   (mmuReq),
    .mmuValid (mmuValid),
    .mmuReady (mmuReady),
    .outReq   (arbReq),
    .outValid (arbValid),
    .outReady (arbReady)
  );

  cp15PipeReg #(.payloadT(cp15ReqT)) u_pipeA (
    .clk      (clk),
    .reset    (reset),
    .inData   (arbReq),
    .inValid  (arbValid),
    .inReady  (arbReady),
    .outData  (pipeAReq),
    .outValid (pipeAValid),
    .outReady (pipeAReady)
  );

  cp15RegisterFile #(
    .idValue      (idValue),
    .controlReset (controlReset)
  ) u_registerFile (
    .clk      (clk),
    .reset    (reset),
    .req      (pipeAReq),
    .reqValid (pipeAValid),
    .reqReady (pipeAReady),
    .rsp      (rfRsp),
    .rspValid (rfValid),
    .rspReady (rfReady),
    .control  (control),
    .tbase    (tbase)
  );

  cp15PipeReg #(.payloadT(cp15RspT)) u_pipeB (
    .clk      (clk),
    .reset    (reset),
    .inData   (rfRsp),
    .inValid  (rfValid),
    .inReady  (rfReady),
    .outData  (pipeBRsp),
    .outValid (pipeBValid),
    .outReady (pipeBReady)
  );

  cp15ResponseRouter u_router (
    .rsp         (pipeBRsp),
    .rspValid    (pipeBValid),
    .rspReady    (pipeBReady),
    .cpuRspData  (cpuRspData),
    .cpuRspValid (cpuRspValid),
    .cpuRspReady (cpuRspReady),
    .mmuRspData  (mmuRspData),
    .mmuRspValid (mmuRspValid),
    .mmuRspReady (mmuRspReady),
    .maint       (maint)
  );

endmodule

//--- list.f
hw/cp15Pkg.sv
hw/cp15PortArbiter.sv
hw/cp15PipeReg.sv
hw/cp15RegisterFile.sv
hw/cp15ResponseRouter.sv
hw/cp15Top.sv
verif/cp15Tb.sv

//--- verif/cp15Tb.sv
`timescale 1ns/1ps

module cp15Tb;

  import cp15Pkg::*;

  localparam logic [31:0] ID_VALUE      = 32'h4106_9265;
  localparam logic [31:0] CONTROL_RESET = 32'h0009_0078;
  localparam int          TRACE_MAX     = 64;
  localparam int          WAIT_LIMIT    = 50;
  localparam int          DRAIN_LIMIT   = 400;
  localparam string       TRACE_FILE    = "verif/cp15Trace.txt";

  // Expected response for one transaction
  typedef struct packed {
    logic [31:0] rdata;
    cp15MaintT   maint;
  } expT;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  cp15PortReqT cpuReq = '0;
  logic        cpuValid = 1'b0;
  logic        cpuReady;
  cp15PortReqT mmuReq = '0;
  logic        mmuValid = 1'b0;
  logic        mmuReady;
  logic [31:0] cpuRspData;
  logic        cpuRspValid;
  logic        cpuRspReady = 1'b1;
  logic [31:0] mmuRspData;
  logic        mmuRspValid;
  logic        mmuRspReady = 1'b1;
  cp15MaintT   maint;
  logic [31:0] control;
  logic [31:0] tbase;

  cp15PortReqT traceReq [TRACE_MAX];
  cp15SrcE     traceSrc [TRACE_MAX];
  expT         traceExp [TRACE_MAX];
  int          traceCount = 0;
  logic [31:0] finalControl = CONTROL_RESET;
  logic [31:0] finalTbase = 32'h0;
  expT         cpuExp [$];
  expT         mmuExp [$];
  int          errorCount = 0;
  int          timeoutCount = 0;
  integer      seed = 32'h78a;
  logic [31:0] readyBits;
  // Last accepted side starts as MMU so the CPU takes the first tie
  cp15SrcE     lastAccepted = CP15_SRC_MMU;

  cp15Top #(
    .idValue      (ID_VALUE),
    .controlReset (CONTROL_RESET)
  ) u_cp15Top (
    .clk         (clk),
    .reset       (reset),
    .cpuReq      (cpuReq),
    .cpuValid    (cpuValid),
    .cpuReady    (cpuReady),
    .mmuReq      (mmuReq),
    .mmuValid    (mmuValid),
    .mmuReady    (mmuReady),
    .cpuRspData  (cpuRspData),
    .cpuRspValid (cpuRspValid),
    .cpuRspReady (cpuRspReady),
    .mmuRspData  (mmuRspData),
    .mmuRspValid (mmuRspValid),
    .mmuRspReady (mmuRspReady),
    .maint       (maint),
    .control     (control),
    .tbase       (tbase)
  );

  always #4 clk = ~clk;

  // Response back-pressure with each port ready about three cycles in four
  always @(posedge clk) begin
    #1;
    readyBits = $random(seed);
    cpuRspReady = readyBits[1:0] != 2'b00;
    mmuRspReady = readyBits[3:2] != 2'b00;
  end

  // ********************
  // Compare tasks
  // ********************

  task automatic checkData(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %08h, got %08h", $time, name, expected, actual);
    end
  endtask

  task automatic checkMaint(input cp15MaintT actual, input cp15MaintT expected);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: maint expected %06b, got %06b", $time, expected, actual);
    end
  endtask

  task automatic checkCtrl(input logic [31:0] expControl, input logic [31:0] expTbase);
    if (control !== expControl) begin
      errorCount++;
      $display("CHECK FAILED at %0t: control expected %08h, got %08h", $time, expControl,
               control);
    end
    if (tbase !== expTbase) begin
      errorCount++;
      $display("CHECK FAILED at %0t: tbase expected %08h, got %08h", $time, expTbase, tbase);
    end
  endtask

  task automatic checkReady(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t: %s expected %0b, got %0b", $time, name, expected, actual);
    end
  endtask

  // ********************
  // Trace handling
  // ********************

  task automatic loadTrace();
    int          fd;
    int          status;
    string       line;
    logic [31:0] portF, writeF, addrF, op2F;
    logic [31:0] crmF, wdataF, rdataF, maintF;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      errorCount++;
      $display("Could not open the trace file %s", TRACE_FILE);
    end else begin
      while (!$feof(fd) && traceCount < TRACE_MAX) begin
        status = $fgets(line, fd);
        // Comment lines fail the scan and are skipped
        if (status != 0) begin
          status = $sscanf(line, "%d %d %h %d %h %h %h %b", portF, writeF, addrF, op2F,
                           crmF, wdataF, rdataF, maintF);
          if (status == 8) begin
            traceSrc[traceCount] = portF[0] ? CP15_SRC_MMU : CP15_SRC_CPU;
            traceReq[traceCount].write = writeF[0];
            traceReq[traceCount].addr = addrF[3:0];
            traceReq[traceCount].opcode2 = op2F[2:0];
            traceReq[traceCount].crm = crmF[3:0];
            traceReq[traceCount].wdata = wdataF;
            traceExp[traceCount].rdata = rdataF;
            traceExp[traceCount].maint = maintF[5:0];
            // Last reads of regs 1 and 2 give the final control and tbase
            if (!writeF[0] && addrF[3:0] == 4'd1) begin
              finalControl = rdataF;
            end
            if (!writeF[0] && addrF[3:0] == 4'd2) begin
              finalTbase = rdataF;
            end
            traceCount++;
          end
        end
      end
      $fclose(fd);
      if (traceCount == 0) begin
        errorCount++;
        $display("The trace file holds no transactions");
      end
    end
  endtask

  // Present one or two trace lines at once and wait until all are accepted
  task automatic issueGroup(input int first, input int count);
    int   k;
    int   waitCycles;
    logic cpuBusy;
    logic mmuBusy;
    logic cpuTaken;
    logic mmuTaken;
    cpuBusy = 1'b0;
    mmuBusy = 1'b0;
    waitCycles = 0;
    for (k = first; k < first + count; k++) begin
      if (traceSrc[k] == CP15_SRC_MMU) begin
        mmuReq = traceReq[k];
        mmuValid = 1'b1;
        mmuBusy = 1'b1;
        mmuExp.push_back(traceExp[k]);
      end else begin
        cpuReq = traceReq[k];
        cpuValid = 1'b1;
        cpuBusy = 1'b1;
        cpuExp.push_back(traceExp[k]);
      end
    end
    while ((cpuBusy || mmuBusy) && waitCycles < WAIT_LIMIT) begin
      @(negedge clk);
      cpuTaken = cpuValid && cpuReady;
      mmuTaken = mmuValid && mmuReady;
      // On a tie only the side that did not go last may see ready
      if (cpuValid && mmuValid) begin
        if (lastAccepted == CP15_SRC_CPU) begin
          checkReady("cpuReady", cpuReady, 1'b0);
        end else begin
          checkReady("mmuReady", mmuReady, 1'b0);
        end
      end
      @(posedge clk);
      #1;
      if (cpuTaken) begin
        cpuValid = 1'b0;
        cpuBusy = 1'b0;
        lastAccepted = CP15_SRC_CPU;
      end
      if (mmuTaken) begin
        mmuValid = 1'b0;
        mmuBusy = 1'b0;
        lastAccepted = CP15_SRC_MMU;
      end
      waitCycles++;
    end
    if (cpuBusy || mmuBusy) begin
      timeoutCount++;
      $display("Timeout: request from trace entry %0d was never accepted", first);
      cpuValid = 1'b0;
      mmuValid = 1'b0;
    end
  endtask

  // ********************
  // Response monitor
  // ********************

  // Sampled mid-cycle as a transfer here completes on the next rising edge
  always @(negedge clk) begin
    expT expNow;
    expNow = '0;
    if (!reset) begin
      if (cpuRspValid && cpuRspReady) begin
        if (cpuExp.size() == 0) begin
          errorCount++;
          $display("Unexpected response on the CPU port at %0t", $time);
        end else begin
          expNow = cpuExp.pop_front();
          checkData("cpuRspData", cpuRspData, expNow.rdata);
        end
      end
      if (mmuRspValid && mmuRspReady) begin
        if (mmuExp.size() == 0) begin
          errorCount++;
          $display("Unexpected response on the MMU port at %0t", $time);
        end else begin
          expNow = mmuExp.pop_front();
          checkData("mmuRspData", mmuRspData, expNow.rdata);
        end
      end
      // Flags only with the transferring response
      checkMaint(maint, expNow.maint);
    end
  end

  // ********************
  // Main sequence
  // ********************

  initial begin
    int i;
    int waitCycles;
    loadTrace();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    checkCtrl(CONTROL_RESET, 32'h0);
    checkMaint(maint, '0);
    if (cpuRspValid || mmuRspValid) begin
      errorCount++;
      $display("A response was valid right after reset");
    end

    i = 0;
    while (i < traceCount) begin
      if (i + 1 < traceCount && traceSrc[i + 1] != traceSrc[i]) begin
        issueGroup(i, 2);
        i += 2;
      end else begin
        issueGroup(i, 1);
        i += 1;
      end
    end

    waitCycles = 0;
    while ((cpuExp.size() != 0 || mmuExp.size() != 0) && waitCycles < DRAIN_LIMIT) begin
      @(posedge clk);
      waitCycles++;
    end
    #1;
    if (cpuExp.size() != 0 || mmuExp.size() != 0) begin
      timeoutCount++;
      $display("Timeout: %0d CPU and %0d MMU responses never arrived", cpuExp.size(),
               mmuExp.size());
    end
    checkCtrl(finalControl, finalTbase);

    $display("Errors: %0d, timeouts: %0d", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verif/cp15Trace.txt
# port(0 cpu 1 mmu) write addr opcode2 crm wdata rdata maint(invI invD cleanI cleanD tlbI tlbD)
# Adjacent lines on different ports are presented in the same cycle
0 0 0 0 0 00000000 41069265 000000
0 1 1 0 0 FFFFFFFF 00000000 000000
0 0 1 0 0 00000000 0009FFFF 000000
0 1 2 0 0 FFFFFFFF 00000000 000000
0 0 2 0 0 00000000 FFFFC000 000000
0 1 3 0 0 FFFFFFFF 00000000 000000
0 0 3 0 0 00000000 FFFFFFFF 000000
1 1 5 0 0 FFFFFFFF 00000000 000000
1 0 5 0 0 00000000 000001FF 000000
1 1 6 0 0 FFFFFFFF 00000000 000000
1 0 6 0 0 00000000 FFFFFFFF 000000
0 1 0 0 0 12345678 00000000 000000
0 0 0 0 0 00000000 41069265 000000
0 1 7 0 5 00000000 00000000 100000
1 1 7 1 5 00000000 00000000 100000
0 1 7 0 6 00000000 00000000 010000
1 1 7 1 6 00000000 00000000 010000
0 1 7 0 7 00000000 00000000 110000
1 1 7 1 7 00000000 00000000 110000
0 1 7 0 a 00000000 00000000 000100
1 1 7 1 a 00000000 00000000 000100
0 1 7 0 b 00000000 00000000 001100
1 1 7 1 b 00000000 00000000 001100
0 1 7 0 e 00000000 00000000 010100
1 1 7 1 e 00000000 00000000 010100
0 1 7 0 f 00000000 00000000 111100
1 1 7 1 f 00000000 00000000 111100
0 1 8 0 5 00000000 00000000 000010
1 1 8 1 5 00000000 00000000 000010
0 1 8 0 6 00000000 00000000 000001
1 1 8 1 6 00000000 00000000 000001
0 1 8 0 7 00000000 00000000 000011
1 1 8 1 7 00000000 00000000 000011
0 1 7 2 f 00000000 00000000 000000
1 1 8 0 9 00000000 00000000 000000
1 1 2 0 0 12345678 00000000 000000
0 1 3 0 0 A5A5A5A5 00000000 000000
1 0 2 0 0 00000000 12344000 000000
0 0 3 0 0 00000000 A5A5A5A5 000000
1 1 1 0 0 00001234 00000000 000000
0 1 5 0 0 00000A5C 00000000 000000
1 0 5 0 0 00000000 0000005C 000000
0 0 1 0 0 00000000 00091234 000000
1 0 2 0 0 00000000 12344000 000000
0 0 6 0 0 00000000 FFFFFFFF 000000
